//--- design/axis_link_consts.svh
// Width, pipeline length and frame limit macros for the stream link
`ifndef AXIS_LINK_CONSTS_SVH
`define AXIS_LINK_CONSTS_SVH

// Beat field widths
`define LINK_DATA_W 32
`define LINK_KEEP_W 4
`define LINK_ID_W 4
`define LINK_DEST_W 4
`define LINK_USER_W 1

// Register stages in each retiming FIFO
`define LINK_INGRESS_LEN 2
`define LINK_EGRESS_LEN 3

// Longest legal frame in beats
`define LINK_MAX_BEATS 8
`define LINK_CNT_W 16

`endif

//--- design/axis_link_pkg.sv
// Stream beat struct and frame monitor state type
`include "axis_link_consts.svh"

package axis_link_pkg;

    // One AXI4-Stream beat, 46 bits
    typedef struct packed {
        logic [`LINK_DATA_W-1:0] data;
        logic [`LINK_KEEP_W-1:0] keep;
        logic last;
        logic [`LINK_ID_W-1:0] id;
        logic [`LINK_DEST_W-1:0] dest;
        // Bit 0 flags a bad frame
        logic [`LINK_USER_W-1:0] user;
    } axis_beat_t;

    // Frame monitor states
    typedef enum logic [1:0] {
        // Waiting for the first beat
        MON_IDLE,
        // Inside a frame, still within the limit
        MON_BODY,
        // Inside a frame that has passed the limit
        MON_OVER
    } mon_state_t;

endpackage

//--- design/axis_pipeline_fifo.sv
// Pipelined stream retiming FIFO with delayed ready and half-full output FIFO
`timescale 1ns/1ps

module axis_pipeline_fifo
    import axis_link_pkg::*;
#(
    parameter int LENGTH = 2
) (
    input  logic       clk,
    input  logic       rst,
    input  axis_beat_t s_beat,
    input  logic       s_valid,
    output logic       s_ready,
    output axis_beat_t m_beat,
    output logic       m_valid,
    input  logic       m_ready
);

    generate
        if (LENGTH > 0) begin : g_pipe
            localparam int FIFO_ADDR_W = (LENGTH < 2) ? 3 : $clog2(LENGTH * 4);
            localparam int PTR_W = FIFO_ADDR_W + 1;
            localparam int DEPTH = 2 ** FIFO_ADDR_W;
            localparam int HALF = 2 ** (FIFO_ADDR_W - 1);

            // Forward beat chain and backward ready chain
            (* shreg_extract = "no" *)
            axis_beat_t stage_beat [LENGTH];
            (* shreg_extract = "no" *)
            logic stage_valid [LENGTH];
            (* shreg_extract = "no" *)
            logic stage_ready [LENGTH];

            (* ram_style = "distributed" *)
            axis_beat_t fifo_mem [DEPTH];

            logic [PTR_W-1:0] wr_ptr;
            logic [PTR_W-1:0] rd_ptr;
            logic [PTR_W-1:0] fifo_fill;
            logic fifo_half_full;
            logic fifo_full;
            logic fifo_empty;
            logic fifo_wr;
            logic fifo_rd;

            axis_beat_t out_beat;
            logic out_valid;

            assign s_ready = stage_ready[0];
            assign m_beat = out_beat;
            assign m_valid = out_valid;

            assign fifo_fill = wr_ptr - rd_ptr;
            assign fifo_full = wr_ptr == (rd_ptr ^ {1'b1, {FIFO_ADDR_W{1'b0}}});
            assign fifo_empty = wr_ptr == rd_ptr;
            // Half full leaves room for every beat still in the chain
            assign fifo_half_full = fifo_fill >= PTR_W'(HALF);

            // Every beat leaving the last stage must land in the FIFO
            assign fifo_wr = stage_valid[LENGTH-1] && !fifo_full;
            // Refill the output register when it is empty or being taken
            assign fifo_rd = !fifo_empty && (!out_valid || m_ready);

            // Payload shift chain
            always_ff @(posedge clk) begin
                stage_beat[0] <= s_beat;
                for (int i = 1; i < LENGTH; i++) begin
                    stage_beat[i] <= stage_beat[i-1];
                end
            end

            // LENGTH-deep valid chain forward and ready chain back
            always_ff @(posedge clk) begin
                if (rst) begin
                    for (int i = 0; i < LENGTH; i++) begin
                        stage_valid[i] <= 1'b0;
                        stage_ready[i] <= 1'b0;
                    end
                end else begin
                    stage_valid[0] <= s_valid && s_ready;
                    stage_ready[LENGTH-1] <= !fifo_half_full;
                    for (int i = 1; i < LENGTH; i++) begin
                        stage_valid[i] <= stage_valid[i-1];
                        stage_ready[i-1] <= stage_ready[i];
                    end
                end
            end

            // FIFO storage
            always_ff @(posedge clk) begin
                if (fifo_wr) begin
                    fifo_mem[wr_ptr[FIFO_ADDR_W-1:0]] <= stage_beat[LENGTH-1];
                end
            end

            // Output register payload
            always_ff @(posedge clk) begin
                if (fifo_rd) begin
                    out_beat <= fifo_mem[rd_ptr[FIFO_ADDR_W-1:0]];
                end
            end

            // Pointers and output valid
            always_ff @(posedge clk) begin
                if (rst) begin
                    wr_ptr <= '0;
                    rd_ptr <= '0;
                    out_valid <= 1'b0;
                end else begin
                    if (fifo_wr) begin
                        wr_ptr <= wr_ptr + 1'b1;
                    end
                    if (fifo_rd) begin
                        rd_ptr <= rd_ptr + 1'b1;
                        out_valid <= 1'b1;
                    end else if (m_ready) begin
                        out_valid <= 1'b0;
                    end
                end
            end
        end else begin : g_bypass
            // Zero length means plain wires
            assign m_beat = s_beat;
            assign m_valid = s_valid;
            assign s_ready = m_ready;
        end
    endgenerate

endmodule

//--- design/frame_len_monitor.sv
// Pass-through frame length checker with oversize marking and frame counters
`timescale 1ns/1ps
`include "axis_link_consts.svh"

module frame_len_monitor
    import axis_link_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  axis_beat_t             in_beat,
    input  logic                   in_valid,
    output logic                   in_ready,
    output axis_beat_t             out_beat,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [`LINK_CNT_W-1:0] frame_count,
    output logic [`LINK_CNT_W-1:0] oversize_count
);

    // Wide enough to hold one beat past the limit
    localparam int BEAT_W = $clog2(`LINK_MAX_BEATS + 2);
    localparam logic [BEAT_W-1:0] MAX_BEATS = BEAT_W'(`LINK_MAX_BEATS);

    mon_state_t state;
    mon_state_t state_next;
    logic [BEAT_W-1:0] beat_cnt;
    logic [BEAT_W-1:0] beat_num;
    logic xfer;
    logic beat_over;
    logic mark;

    // Handshake passes straight through
    assign out_valid = in_valid;
    assign in_ready = out_ready;
    assign xfer = in_valid && out_ready;

    // Ordinal of the beat now on the input
    assign beat_num = beat_cnt + 1'b1;
    assign beat_over = (state == MON_OVER) || (beat_num > MAX_BEATS);
    assign mark = in_beat.last && beat_over;

    always_comb begin
        out_beat = in_beat;
        out_beat.user[0] = in_beat.user[0] | mark;
    end

    always_comb begin
        state_next = state;
        if (in_beat.last) begin
            state_next = MON_IDLE;
        end else if (beat_over) begin
            state_next = MON_OVER;
        end else begin
            state_next = MON_BODY;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= MON_IDLE;
            beat_cnt <= '0;
        end else if (xfer) begin
            state <= state_next;
            case (state_next)
                MON_IDLE: beat_cnt <= '0;
                MON_BODY: beat_cnt <= beat_num;
                // Count stops once the frame is known to be too long
                default: beat_cnt <= beat_cnt;
            endcase
        end
    end

    // Frame statistics, wrapping
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_count <= '0;
            oversize_count <= '0;
        end else if (xfer && in_beat.last) begin
            frame_count <= frame_count + 1'b1;
            if (mark) begin
                oversize_count <= oversize_count + 1'b1;
            end
        end
    end

endmodule

//--- design/axis_link_top.sv
// Stream link top level with ingress FIFO, frame monitor and egress FIFO
`timescale 1ns/1ps
`include "axis_link_consts.svh"

module axis_link_top
    import axis_link_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  axis_beat_t             s_beat,
    input  logic                   s_valid,
    output logic                   s_ready,
    output axis_beat_t             m_beat,
    output logic                   m_valid,
    input  logic                   m_ready,
    output logic [`LINK_CNT_W-1:0] frame_count,
    output logic [`LINK_CNT_W-1:0] oversize_count
);

    // Ingress FIFO to monitor
    axis_beat_t mid_beat;
    logic mid_valid;
    logic mid_ready;

    // Monitor to egress FIFO
    axis_beat_t mon_beat;
    logic mon_valid;
    logic mon_ready;

    axis_pipeline_fifo #(
        .LENGTH(`LINK_INGRESS_LEN)
    ) u_ingress (
        .clk(clk),
        .rst(rst),
        .s_beat(s_beat),
        .s_valid(s_valid),
        .s_ready(s_ready),
        .m_beat(mid_beat),
        .m_valid(mid_valid),
        .m_ready(mid_ready)
    );

    frame_len_monitor u_monitor (
        .clk(clk),
        .rst(rst),
        .in_beat(mid_beat),
        .in_valid(mid_valid),
        .in_ready(mid_ready),
        .out_beat(mon_beat),
        .out_valid(mon_valid),
        .out_ready(mon_ready),
        .frame_count(frame_count),
        .oversize_count(oversize_count)
    );

    axis_pipeline_fifo #(
        .LENGTH(`LINK_EGRESS_LEN)
    ) u_egress (
        .clk(clk),
        .rst(rst),
        .s_beat(mon_beat),
        .s_valid(mon_valid),
        .s_ready(mon_ready),
        .m_beat(m_beat),
        .m_valid(m_valid),
        .m_ready(m_ready)
    );

endmodule

//--- test/axis_link_assert.sv
// Concurrent checks on the stream link top-level ports and their bind
`timescale 1ns/1ps

module axis_link_assert
    import axis_link_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       s_ready,
    input axis_beat_t m_beat,
    input logic       m_valid,
    input logic       m_ready
);

    // Cycles allowed for s_ready to come up after reset
    localparam int READY_LIMIT = 32;

    logic ready_seen;
    logic [5:0] ready_wait;

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_seen <= 1'b0;
            ready_wait <= '0;
        end else if (s_ready) begin
            ready_seen <= 1'b1;
        end else if (!ready_seen && ready_wait != '1) begin
            ready_wait <= ready_wait + 1'b1;
        end
    end

    quiet_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !m_valid && !s_ready)
        else $error("m_valid or s_ready high during reset");

    hold_until_taken: assert property (@(posedge clk) disable iff (rst)
        m_valid && !m_ready |=> m_valid && $stable(m_beat))
        else $error("m_valid or m_beat changed before the beat was taken");

    ready_after_reset: assert property (@(posedge clk) disable iff (rst)
        !ready_seen |-> ready_wait < READY_LIMIT)
        else $error("s_ready did not rise after reset");

endmodule

bind axis_link_top axis_link_assert u_link_assert (
    .clk(clk),
    .rst(rst),
    .s_ready(s_ready),
    .m_beat(m_beat),
    .m_valid(m_valid),
    .m_ready(m_ready)
);

//--- test/axis_link_tb.sv
// Directed testbench for the stream link with reference queue, counter checks and timeout
`timescale 1ns/1ps
`include "axis_link_consts.svh"

module axis_link_tb
    import axis_link_pkg::*;
();

    localparam int CLK_HALF = 5;
    localparam int RESET_CYCLES = 8;
    localparam int CNT_W = `LINK_CNT_W;
    // Four times the roughly 1000 cycles of beats and idle time in all tests
    localparam int TIMEOUT_CYCLES = 4000;

    typedef enum {SINK_OPEN, SINK_HOLD, SINK_RANDOM} sink_mode_t;

    logic clk;
    logic rst;
    axis_beat_t s_beat;
    logic s_valid;
    logic s_ready;
    axis_beat_t m_beat;
    logic m_valid;
    logic m_ready;
    logic [CNT_W-1:0] frame_count;
    logic [CNT_W-1:0] oversize_count;

    // Reference model state
    axis_beat_t exp_q[$];
    int model_beats;
    logic [CNT_W-1:0] exp_frames;
    logic [CNT_W-1:0] exp_oversize;

    int seed;
    int cycle_count = 0;
    sink_mode_t sink_mode;
    logic ready_draw;

    axis_link_top UUT (
        .clk(clk),
        .rst(rst),
        .s_beat(s_beat),
        .s_valid(s_valid),
        .s_ready(s_ready),
        .m_beat(m_beat),
        .m_valid(m_valid),
        .m_ready(m_ready),
        .frame_count(frame_count),
        .oversize_count(oversize_count)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d beats still expected",
                     cycle_count, exp_q.size());
            $display("Simulation failed");
            $fatal(1, "Run stopped on timeout");
        end
    end

    // Random ready is drawn on the rising edge and applied on the falling one
    always @(posedge clk) begin
        if (sink_mode == SINK_RANDOM) begin
            ready_draw = 1'($random(seed));
        end
    end

    // Sink drives m_ready and checks the beat that the next rising edge takes
    always @(negedge clk) begin
        case (sink_mode)
            SINK_OPEN: m_ready = 1'b1;
            SINK_HOLD: m_ready = 1'b0;
            default: m_ready = ready_draw;
        endcase
        if (!rst && m_valid && m_ready) begin
            check_output(m_beat);
        end
    end

    task automatic fail_run();
        $display("Simulation failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic compare_beat(input string name, input axis_beat_t exp, input axis_beat_t act);
        if (act !== exp) begin
            $display("** Error: %s expected %h, actual %h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic compare_count(input string name, input logic [CNT_W-1:0] exp,
                                 input logic [CNT_W-1:0] act);
        if (act !== exp) begin
            $display("** Error: %s expected %h, actual %h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_output(input axis_beat_t act);
        axis_beat_t exp;
        if (exp_q.size() == 0) begin
            $display("An output beat arrived while no beat was expected");
            fail_run();
        end else begin
            exp = exp_q.pop_front();
            compare_beat("m_beat", exp, act);
        end
    endtask

    // Last beat of a frame longer than the limit gets user bit 0
    task automatic model_accept(input axis_beat_t beat);
        axis_beat_t exp;
        exp = beat;
        model_beats++;
        if (beat.last) begin
            exp_frames++;
            if (model_beats > `LINK_MAX_BEATS) begin
                exp.user[0] = 1'b1;
                exp_oversize++;
            end
            model_beats = 0;
        end
        exp_q.push_back(exp);
    endtask

    task automatic check_counts();
        compare_count("frame_count", exp_frames, frame_count);
        compare_count("oversize_count", exp_oversize, oversize_count);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        s_valid = 1'b0;
        exp_q.delete();
        model_beats = 0;
        exp_frames = '0;
        exp_oversize = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic build_beat(input bit last, input bit user_bit, output axis_beat_t beat);
        logic [31:0] rnd;
        rnd = $random(seed);
        beat.data = rnd;
        rnd = $random(seed);
        beat.keep = `LINK_KEEP_W'(rnd);
        beat.id = `LINK_ID_W'(rnd >> 8);
        beat.dest = `LINK_DEST_W'(rnd >> 16);
        beat.last = last;
        beat.user = `LINK_USER_W'(user_bit);
    endtask

    // Called on a falling edge where the registered s_ready is stable
    task automatic drive_beat(input axis_beat_t beat);
        s_beat = beat;
        s_valid = 1'b1;
        while (!s_ready) begin
            @(negedge clk);
        end
        model_accept(beat);
        @(negedge clk);
        s_valid = 1'b0;
    endtask

    task automatic send_frame(input int len, input logic [31:0] user_pattern, input bit closed);
        axis_beat_t beat;
        for (int i = 0; i < len; i++) begin
            build_beat(closed && (i == len - 1), user_pattern[i % 32], beat);
            drive_beat(beat);
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic short_frames_in_order();
        sink_mode = SINK_OPEN;
        send_frame(1, 32'h0, 1'b1);
        send_frame(1, 32'h0, 1'b1);
        send_frame(2, 32'h0, 1'b1);
        send_frame(3, 32'h0, 1'b1);
        send_frame(4, 32'h0, 1'b1);
        send_frame(5, 32'h0, 1'b1);
        wait_drain();
        compare_count("frame_count", CNT_W'(6), frame_count);
        check_counts();
    endtask

    task automatic length_limit_marking();
        logic [CNT_W-1:0] prev;
        prev = exp_oversize;
        send_frame(`LINK_MAX_BEATS, 32'h0, 1'b1);
        wait_drain();
        compare_count("oversize_count", prev, oversize_count);
        send_frame(`LINK_MAX_BEATS + 1, 32'h0, 1'b1);
        wait_drain();
        compare_count("oversize_count", prev + 1'b1, oversize_count);
        send_frame(`LINK_MAX_BEATS + 5, 32'h0, 1'b1);
        wait_drain();
        check_counts();
    endtask

    task automatic user_bit_passthrough();
        send_frame(5, 32'h0000_0015, 1'b1);
        send_frame(`LINK_MAX_BEATS + 2, 32'hffff_ffff, 1'b1);
        send_frame(3, 32'h0000_0004, 1'b1);
        wait_drain();
        check_counts();
    endtask

    task automatic backpressure_no_loss();
        bit saw_stall;
        saw_stall = 1'b0;
        sink_mode = SINK_HOLD;
        fork
            begin
                for (int f = 0; f < 8; f++) begin
                    send_frame(6, 32'h0, 1'b1);
                end
            end
            begin
                repeat (40) begin
                    @(negedge clk);
                    if (!s_ready) begin
                        saw_stall = 1'b1;
                    end
                end
                sink_mode = SINK_OPEN;
            end
        join
        if (!saw_stall) begin
            $display("s_ready never fell while m_ready was held low");
            fail_run();
        end
        wait_drain();
        check_counts();
    endtask

    task automatic random_ready_order();
        logic [31:0] rnd;
        logic [31:0] pattern;
        int len;
        sink_mode = SINK_RANDOM;
        for (int f = 0; f < 20; f++) begin
            rnd = $random(seed);
            len = 1 + int'(rnd[3:0] % 4'd12);
            pattern = $random(seed) & 32'h0000_0041;
            send_frame(len, pattern, 1'b1);
            repeat (rnd[9:8]) @(negedge clk);
        end
        wait_drain();
        sink_mode = SINK_OPEN;
        check_counts();
    endtask

    task automatic reset_mid_frame();
        send_frame(7, 32'h0, 1'b0);
        repeat (3) @(negedge clk);
        apply_reset();
        compare_count("frame_count", '0, frame_count);
        compare_count("oversize_count", '0, oversize_count);
        // Seven stale beats plus these four would pass the limit
        send_frame(4, 32'h0, 1'b1);
        wait_drain();
        compare_count("frame_count", CNT_W'(1), frame_count);
        compare_count("oversize_count", '0, oversize_count);
    endtask

    initial begin
        seed = 52349;
        rst = 1'b1;
        s_valid = 1'b0;
        s_beat = '0;
        m_ready = 1'b1;
        ready_draw = 1'b1;
        sink_mode = SINK_OPEN;
        apply_reset();
        short_frames_in_order();
        length_limit_marking();
        user_bit_passthrough();
        backpressure_no_loss();
        random_ready_order();
        reset_mid_frame();
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- src.f
+incdir+design
design/axis_link_pkg.sv
design/axis_pipeline_fifo.sv
design/frame_len_monitor.sv
design/axis_link_top.sv
test/axis_link_assert.sv
test/axis_link_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the stream link testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM_BIN=axis_link_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module axis_link_tb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN" \
    -f src.f
status=$?
if [ $status -ne 0 ]; then
    echo "Build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
    echo "Run result: PASS"
    exit 0
else
    echo "Run result: FAIL"
    exit 1
fi
